//--- src/load_pipe_pkg.sv
package load_pipe_pkg;

    // Sizes
    localparam int PHYS_REG_BITS = 6;
    localparam int SQ_IDX_BITS = 3;
    localparam int MEM_WORDS = 256;
    localparam int MEM_ADDR_BITS = $clog2(MEM_WORDS);
    localparam int LOAD_BUFFER_DEPTH = 4;
    localparam int LOAD_BUFFER_PTR_BITS = $clog2(LOAD_BUFFER_DEPTH);
    localparam int LOAD_BUFFER_COUNT_BITS = $clog2(LOAD_BUFFER_DEPTH + 1);

    typedef logic [31:0] data_t;
    typedef logic [3:0] byte_mask_t;
    typedef logic [PHYS_REG_BITS-1:0] phys_reg_t;
    typedef logic [SQ_IDX_BITS-1:0] sq_idx_t;
    typedef logic [LOAD_BUFFER_PTR_BITS-1:0] lb_ptr_t;
    typedef logic [LOAD_BUFFER_COUNT_BITS-1:0] lb_count_t;

    localparam lb_ptr_t LOAD_BUFFER_LAST_PTR = lb_ptr_t'(LOAD_BUFFER_DEPTH - 1);
    localparam lb_count_t LOAD_BUFFER_FULL = lb_count_t'(LOAD_BUFFER_DEPTH);

    // Marker values for select codes the muxes do not handle
    localparam data_t OPA_MARKER = 32'hdeadface;
    localparam data_t OPB_MARKER = 32'hfacefeed;

    // NPC and PC sources are not supported here
    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'h0,
        OPA_IS_ZERO = 2'h3
    } opa_select_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'h0,
        OPB_IS_I_IMM = 3'h1,
        OPB_IS_S_IMM = 3'h2,
        OPB_IS_B_IMM = 3'h3,
        OPB_IS_U_IMM = 3'h4,
        OPB_IS_J_IMM = 3'h5
    } opb_select_e;

    // funct3[1:0] of a load, funct3[2] marks unsigned
    typedef enum logic [1:0] {
        BYTE = 2'h0,
        HALF = 2'h1,
        WORD = 2'h2
    } mem_size_e;

    typedef struct packed {
        logic        valid;
        data_t       inst;
        data_t       source_reg_1;
        data_t       source_reg_2;
        opa_select_e opa_select;
        opb_select_e opb_select;
        phys_reg_t   dest_reg_idx;
        sq_idx_t     sq_tail;
    } load_addr_packet_t;

    localparam load_addr_packet_t NOP_LOAD_ADDR_PACKET = '{
        valid:        1'b0,
        inst:         '0,
        source_reg_1: '0,
        source_reg_2: '0,
        opa_select:   OPA_IS_RS1,
        opb_select:   OPB_IS_RS2,
        dest_reg_idx: '0,
        sq_tail:      '0
    };

    // RV32 immediates, all sign-extended from inst[31]
    function automatic data_t imm_i(input data_t inst);
        return {{21{inst[31]}}, inst[30:20]};
    endfunction

    function automatic data_t imm_s(input data_t inst);
        return {{21{inst[31]}}, inst[30:25], inst[11:7]};
    endfunction

    function automatic data_t imm_b(input data_t inst);
        return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic data_t imm_u(input data_t inst);
        return {inst[31:12], 12'h000};
    endfunction

    function automatic data_t imm_j(input data_t inst);
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage

//--- src/load_data_if.sv
`timescale 1ns/1ps

interface load_data_if;

    logic                     valid;
    load_pipe_pkg::phys_reg_t  dest_reg_idx;
    load_pipe_pkg::data_t      load_addr;
    load_pipe_pkg::byte_mask_t byte_mask;
    logic [2:0]                funct3;
    load_pipe_pkg::sq_idx_t    sq_tail;
    logic                      free;

    modport addr_side (
        output valid, dest_reg_idx, load_addr, byte_mask, funct3, sq_tail,
        input  free
    );

    modport data_side (
        input  valid, dest_reg_idx, load_addr, byte_mask, funct3, sq_tail,
        output free
    );

endinterface

//--- src/load_result_if.sv
`timescale 1ns/1ps

interface load_result_if;

    logic                     valid;
    load_pipe_pkg::phys_reg_t dest_reg_idx;
    load_pipe_pkg::data_t     value;
    load_pipe_pkg::sq_idx_t   sq_tail;

    // High while the buffer has room
    logic                     free;

    modport data_side (
        output valid, dest_reg_idx, value, sq_tail,
        input  free
    );

    modport buffer_side (
        input  valid, dest_reg_idx, value, sq_tail,
        output free
    );

endinterface

//--- src/load_addr_stage.sv
`timescale 1ns/1ps

module load_addr_stage (
    input  logic                             clock,
    input  logic                             reset,
    input  load_pipe_pkg::load_addr_packet_t issue_packet,
    output logic                             issue_ready,
    load_data_if.addr_side                   to_data
);

    load_pipe_pkg::load_addr_packet_t load_reg;

    load_pipe_pkg::data_t      opa;
    load_pipe_pkg::data_t      opb;
    load_pipe_pkg::data_t      eff_addr;
    load_pipe_pkg::byte_mask_t size_mask;
    logic [2:0]                funct3;

    // Free when the held load can leave this cycle or nothing is held
    assign issue_ready = to_data.free || !load_reg.valid;

    assign funct3 = load_reg.inst[14:12];
    assign eff_addr = opa + opb;

    assign to_data.valid = load_reg.valid;
    assign to_data.dest_reg_idx = load_reg.dest_reg_idx;
    assign to_data.load_addr = eff_addr;
    assign to_data.byte_mask = size_mask << eff_addr[1:0];
    assign to_data.funct3 = funct3;
    assign to_data.sq_tail = load_reg.sq_tail;

    // Operand A
    always_comb begin
        case (load_reg.opa_select)
            load_pipe_pkg::OPA_IS_RS1:  opa = load_reg.source_reg_1;
            load_pipe_pkg::OPA_IS_ZERO: opa = '0;
            default:                    opa = load_pipe_pkg::OPA_MARKER;
        endcase
    end

    // Operand B
    always_comb begin
        case (load_reg.opb_select)
            load_pipe_pkg::OPB_IS_RS2:   opb = load_reg.source_reg_2;
            load_pipe_pkg::OPB_IS_I_IMM: opb = load_pipe_pkg::imm_i(load_reg.inst);
            load_pipe_pkg::OPB_IS_S_IMM: opb = load_pipe_pkg::imm_s(load_reg.inst);
            load_pipe_pkg::OPB_IS_B_IMM: opb = load_pipe_pkg::imm_b(load_reg.inst);
            load_pipe_pkg::OPB_IS_U_IMM: opb = load_pipe_pkg::imm_u(load_reg.inst);
            load_pipe_pkg::OPB_IS_J_IMM: opb = load_pipe_pkg::imm_j(load_reg.inst);
            default:                     opb = load_pipe_pkg::OPB_MARKER;
        endcase
    end

    // Lanes covered by the access size, before the offset shift
    always_comb begin
        case (load_pipe_pkg::mem_size_e'(funct3[1:0]))
            load_pipe_pkg::BYTE: size_mask = 4'b0001;
            load_pipe_pkg::HALF: size_mask = 4'b0011;
            load_pipe_pkg::WORD: size_mask = 4'b1111;
            default:             size_mask = 4'b0000;
        endcase
    end

    // An idle issue port loads an empty packet, which drains the stage
    always_ff @(posedge clock) begin
        if (reset) begin
            load_reg <= load_pipe_pkg::NOP_LOAD_ADDR_PACKET;
        end else if (issue_ready) begin
            load_reg <= issue_packet;
        end
    end

endmodule

//--- src/load_data_stage.sv
`timescale 1ns/1ps

module load_data_stage (
    input  logic                                     clock,
    input  logic                                     reset,
    load_data_if.data_side                           from_addr,
    load_result_if.data_side                         to_buffer,
    output logic                                     mem_rd_en,
    output logic [load_pipe_pkg::MEM_ADDR_BITS-1:0]  mem_rd_addr,
    input  load_pipe_pkg::data_t                     mem_rd_data
);

    logic                      ld_valid;
    load_pipe_pkg::phys_reg_t  ld_dest_reg_idx;
    logic [1:0]                ld_offset;
    load_pipe_pkg::byte_mask_t ld_byte_mask;
    logic [2:0]                ld_funct3;
    load_pipe_pkg::sq_idx_t    ld_sq_tail;

    load_pipe_pkg::data_t lane_data;
    load_pipe_pkg::data_t aligned;
    load_pipe_pkg::data_t load_value;

    assign from_addr.free = !ld_valid || to_buffer.free;

    // Memory is read only for an accepted load, so its output holds during a stall
    assign mem_rd_en = from_addr.valid && from_addr.free;
    assign mem_rd_addr = from_addr.load_addr[load_pipe_pkg::MEM_ADDR_BITS+1:2];

    always_ff @(posedge clock) begin
        if (reset) begin
            ld_valid <= 1'b0;
        end else if (from_addr.free) begin
            ld_valid <= from_addr.valid;
        end
    end

    always_ff @(posedge clock) begin
        if (from_addr.free) begin
            ld_dest_reg_idx <= from_addr.dest_reg_idx;
            ld_offset <= from_addr.load_addr[1:0];
            ld_byte_mask <= from_addr.byte_mask;
            ld_funct3 <= from_addr.funct3;
            ld_sq_tail <= from_addr.sq_tail;
        end
    end

    // Keep the addressed lanes and move them down to bit 0
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            lane_data[8*i +: 8] = ld_byte_mask[i] ? mem_rd_data[8*i +: 8] : 8'h00;
        end
        aligned = lane_data >> {ld_offset, 3'b000};
    end

    // funct3[2] selects zero extension
    always_comb begin
        case (load_pipe_pkg::mem_size_e'(ld_funct3[1:0]))
            load_pipe_pkg::BYTE: begin
                load_value = {{24{aligned[7] & ~ld_funct3[2]}}, aligned[7:0]};
            end
            load_pipe_pkg::HALF: begin
                load_value = {{16{aligned[15] & ~ld_funct3[2]}}, aligned[15:0]};
            end
            default: load_value = aligned;
        endcase
    end

    assign to_buffer.valid = ld_valid;
    assign to_buffer.dest_reg_idx = ld_dest_reg_idx;
    assign to_buffer.value = load_value;
    assign to_buffer.sq_tail = ld_sq_tail;

endmodule

//--- src/data_mem.sv
`timescale 1ns/1ps

module data_mem (
    input  logic                                    clock,
    input  logic                                    wr_en,
    input  logic [load_pipe_pkg::MEM_ADDR_BITS-1:0] wr_addr,
    input  load_pipe_pkg::data_t                    wr_data,
    input  load_pipe_pkg::byte_mask_t               wr_mask,
    input  logic                                    rd_en,
    input  logic [load_pipe_pkg::MEM_ADDR_BITS-1:0] rd_addr,
    output load_pipe_pkg::data_t                    rd_data
);

    load_pipe_pkg::data_t mem [load_pipe_pkg::MEM_WORDS];

    // Byte-lane write
    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_mask[i]) begin
                    mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // Read register keeps its value while rd_en is low
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- src/load_buffer.sv
`timescale 1ns/1ps

module load_buffer (
    input  logic                      clock,
    input  logic                      reset,
    load_result_if.buffer_side        push,
    output logic                      cdb_valid,
    output load_pipe_pkg::phys_reg_t  cdb_dest_reg_idx,
    output load_pipe_pkg::data_t      cdb_value,
    output load_pipe_pkg::sq_idx_t    cdb_sq_tail,
    input  logic                      cdb_grant
);

    load_pipe_pkg::phys_reg_t entry_dest [load_pipe_pkg::LOAD_BUFFER_DEPTH];
    load_pipe_pkg::data_t     entry_value [load_pipe_pkg::LOAD_BUFFER_DEPTH];
    load_pipe_pkg::sq_idx_t   entry_sq_tail [load_pipe_pkg::LOAD_BUFFER_DEPTH];

    load_pipe_pkg::lb_ptr_t   head;
    load_pipe_pkg::lb_ptr_t   tail;
    load_pipe_pkg::lb_count_t count;

    logic push_fire;
    logic pop_fire;

    // A full buffer refuses a push even when the head leaves that cycle
    assign push.free = (count != load_pipe_pkg::LOAD_BUFFER_FULL);
    assign push_fire = push.valid && push.free;
    assign pop_fire = cdb_valid && cdb_grant;

    assign cdb_valid = (count != '0);
    assign cdb_dest_reg_idx = entry_dest[head];
    assign cdb_value = entry_value[head];
    assign cdb_sq_tail = entry_sq_tail[head];

    always_ff @(posedge clock) begin
        if (push_fire) begin
            entry_dest[tail] <= push.dest_reg_idx;
            entry_value[tail] <= push.value;
            entry_sq_tail[tail] <= push.sq_tail;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push_fire) begin
                tail <= (tail == load_pipe_pkg::LOAD_BUFFER_LAST_PTR) ? '0 : tail + 1'b1;
            end
            if (pop_fire) begin
                head <= (head == load_pipe_pkg::LOAD_BUFFER_LAST_PTR) ? '0 : head + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- src/load_pipe.sv
`timescale 1ns/1ps

module load_pipe (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    issue_valid,
    input  load_pipe_pkg::data_t                    issue_inst,
    input  load_pipe_pkg::data_t                    issue_rs1_value,
    input  load_pipe_pkg::data_t                    issue_rs2_value,
    input  load_pipe_pkg::opa_select_e              issue_opa_select,
    input  load_pipe_pkg::opb_select_e              issue_opb_select,
    input  load_pipe_pkg::phys_reg_t                issue_dest_reg_idx,
    input  load_pipe_pkg::sq_idx_t                  issue_sq_tail,
    output logic                                    issue_ready,
    input  logic                                    mem_wr_en,
    input  logic [load_pipe_pkg::MEM_ADDR_BITS-1:0] mem_wr_addr,
    input  load_pipe_pkg::data_t                    mem_wr_data,
    input  load_pipe_pkg::byte_mask_t               mem_wr_mask,
    output logic                                    cdb_valid,
    output load_pipe_pkg::phys_reg_t                cdb_dest_reg_idx,
    output load_pipe_pkg::data_t                    cdb_value,
    output load_pipe_pkg::sq_idx_t                  cdb_sq_tail,
    input  logic                                    cdb_grant
);

    load_pipe_pkg::load_addr_packet_t issue_packet;

    logic                                    mem_rd_en;
    logic [load_pipe_pkg::MEM_ADDR_BITS-1:0] mem_rd_addr;
    load_pipe_pkg::data_t                    mem_rd_data;

    load_data_if   data_bus ();
    load_result_if result_bus ();

    always_comb begin
        issue_packet.valid = issue_valid;
        issue_packet.inst = issue_inst;
        issue_packet.source_reg_1 = issue_rs1_value;
        issue_packet.source_reg_2 = issue_rs2_value;
        issue_packet.opa_select = issue_opa_select;
        issue_packet.opb_select = issue_opb_select;
        issue_packet.dest_reg_idx = issue_dest_reg_idx;
        issue_packet.sq_tail = issue_sq_tail;
    end

    load_addr_stage u_load_addr_stage (
        .clock        (clock),
        .reset        (reset),
        .issue_packet (issue_packet),
        .issue_ready  (issue_ready),
        .to_data      (data_bus.addr_side)
    );

    load_data_stage u_load_data_stage (
        .clock       (clock),
        .reset       (reset),
        .from_addr   (data_bus.data_side),
        .to_buffer   (result_bus.data_side),
        .mem_rd_en   (mem_rd_en),
        .mem_rd_addr (mem_rd_addr),
        .mem_rd_data (mem_rd_data)
    );

    // Write port is for preloading from outside
    data_mem u_data_mem (
        .clock   (clock),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .wr_mask (mem_wr_mask),
        .rd_en   (mem_rd_en),
        .rd_addr (mem_rd_addr),
        .rd_data (mem_rd_data)
    );

    load_buffer u_load_buffer (
        .clock            (clock),
        .reset            (reset),
        .push             (result_bus.buffer_side),
        .cdb_valid        (cdb_valid),
        .cdb_dest_reg_idx (cdb_dest_reg_idx),
        .cdb_value        (cdb_value),
        .cdb_sq_tail      (cdb_sq_tail),
        .cdb_grant        (cdb_grant)
    );

endmodule

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock
);

    localparam time CLOCK_PERIOD = 100ns;

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

endmodule

//--- test/load_pipe_tb.sv
`timescale 1ns/1ps

module load_pipe_tb;

    localparam int TOTAL_ISSUES = 230;
    localparam int WATCHDOG_CYCLES = TOTAL_ISSUES * 20 + load_pipe_pkg::MEM_WORDS + 200;
    // Buffer entries plus one load in each stage
    localparam int PIPE_CAPACITY = load_pipe_pkg::LOAD_BUFFER_DEPTH + 2;
    // Longest wait for the pipe to empty after the last issue of a test
    localparam int DRAIN_CYCLES = 200;

    typedef struct packed {
        load_pipe_pkg::phys_reg_t dest;
        load_pipe_pkg::data_t     value;
        load_pipe_pkg::sq_idx_t   sq;
    } result_t;

    logic                                    clock;
    logic                                    reset;
    logic                                    issue_valid;
    load_pipe_pkg::data_t                    issue_inst;
    load_pipe_pkg::data_t                    issue_rs1_value;
    load_pipe_pkg::data_t                    issue_rs2_value;
    load_pipe_pkg::opa_select_e              issue_opa_select;
    load_pipe_pkg::opb_select_e              issue_opb_select;
    load_pipe_pkg::phys_reg_t                issue_dest_reg_idx;
    load_pipe_pkg::sq_idx_t                  issue_sq_tail;
    logic                                    issue_ready;
    logic                                    mem_wr_en;
    logic [load_pipe_pkg::MEM_ADDR_BITS-1:0] mem_wr_addr;
    load_pipe_pkg::data_t                    mem_wr_data;
    load_pipe_pkg::byte_mask_t               mem_wr_mask;
    logic                                    cdb_valid;
    load_pipe_pkg::phys_reg_t                cdb_dest_reg_idx;
    load_pipe_pkg::data_t                    cdb_value;
    load_pipe_pkg::sq_idx_t                  cdb_sq_tail;
    logic                                    cdb_grant;

    load_pipe_pkg::data_t model_mem [load_pipe_pkg::MEM_WORDS];
    result_t              exp_q [$];
    result_t              exp_head;
    logic                 head_valid = 1'b0;
    integer               seed = 63612;
    integer               grant_seed = 63612;
    int                   errors = 0;
    int                   checks = 0;
    // 0 holds grant low, 1 holds it high, 2 randomizes it
    int                   grant_mode = 1;

    tb_clock_gen u_clock_gen (.clock(clock));

    load_pipe u_load_pipe (.*);

    // Reference load result from the model memory
    function automatic load_pipe_pkg::data_t expected_load(input load_pipe_pkg::data_t addr,
                                                           input logic [2:0] funct3);
        load_pipe_pkg::data_t word;
        logic [7:0]           lane_byte;
        logic [15:0]          lane_half;
        word = model_mem[addr[load_pipe_pkg::MEM_ADDR_BITS+1:2]];
        lane_byte = word[8*addr[1:0] +: 8];
        lane_half = addr[1] ? word[31:16] : word[15:0];
        case (funct3)
            3'b000:  return {{24{lane_byte[7]}}, lane_byte};
            3'b100:  return {24'h000000, lane_byte};
            3'b001:  return {{16{lane_half[15]}}, lane_half};
            3'b101:  return {16'h0000, lane_half};
            default: return word;
        endcase
    endfunction

    // Starts and ends on a falling edge; operands are chosen so that opa + opb == addr
    task automatic issue_load(input logic [2:0] funct3, input load_pipe_pkg::opa_select_e opa,
                              input load_pipe_pkg::opb_select_e opb,
                              input load_pipe_pkg::data_t addr, input logic [11:0] imm);
        load_pipe_pkg::data_t imm_ext;
        load_pipe_pkg::data_t rs1;
        load_pipe_pkg::data_t rs2;
        result_t              exp;
        imm_ext = {{20{imm[11]}}, imm};
        rs1 = load_pipe_pkg::data_t'($random(seed));
        rs2 = load_pipe_pkg::data_t'($random(seed));
        if (opb == load_pipe_pkg::OPB_IS_RS2) begin
            rs2 = (opa == load_pipe_pkg::OPA_IS_ZERO) ? addr : addr - rs1;
        end else if (opa == load_pipe_pkg::OPA_IS_RS1) begin
            rs1 = addr - imm_ext;
        end
        if (opb == load_pipe_pkg::OPB_IS_S_IMM) begin
            issue_inst = {imm[11:5], 5'd2, 5'd1, funct3, imm[4:0], 7'b0000011};
        end else begin
            issue_inst = {imm, 5'd1, funct3, 5'd5, 7'b0000011};
        end
        exp.dest = load_pipe_pkg::phys_reg_t'($random(seed));
        exp.sq = load_pipe_pkg::sq_idx_t'($random(seed));
        exp.value = expected_load(addr, funct3);
        issue_rs1_value = rs1;
        issue_rs2_value = rs2;
        issue_opa_select = opa;
        issue_opb_select = opb;
        issue_dest_reg_idx = exp.dest;
        issue_sq_tail = exp.sq;
        issue_valid = 1'b1;
        // issue_ready only moves on a rising edge, so a high level here means taken
        while (!issue_ready) @(negedge clock);
        exp_q.push_back(exp);
        @(negedge clock);
        issue_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || cdb_valid) && cycles < DRAIN_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        check_level(exp_q.size() != 0 || cdb_valid, 1'b0, "results outstanding after drain");
    endtask

    task automatic check_level(input logic actual, input logic expected, input string what);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        $display("Test %s: %s", name, (errors == errors_before) ? "passed" : "failed");
    endtask

    function automatic load_pipe_pkg::data_t random_word_addr();
        return load_pipe_pkg::data_t'($random(seed)) & 32'h0000_03fc;
    endfunction

    // Scoreboard pops granted entries; the head is registered for the assertions
    always @(posedge clock) begin
        if (!reset && cdb_valid && cdb_grant && exp_q.size() != 0) begin
            exp_q.delete(0);
            checks++;
        end
        head_valid <= (exp_q.size() != 0);
        if (exp_q.size() != 0) begin
            exp_head <= exp_q[0];
        end
    end

    a_result_expected: assert property (@(posedge clock) disable iff (reset)
        (cdb_valid && cdb_grant) |-> head_valid)
        else begin
            errors++;
            $display("Bus granted a load result at %0t with no load outstanding", $time);
        end

    a_result_match: assert property (@(posedge clock) disable iff (reset)
        (cdb_valid && cdb_grant && head_valid) |->
        (cdb_value == exp_head.value && cdb_dest_reg_idx == exp_head.dest &&
         cdb_sq_tail == exp_head.sq))
        else begin
            errors++;
            $display("[FAIL] %0t: bus gave dest %0d value %h sq %0d, expected %0d %h %0d",
                     $time, cdb_dest_reg_idx, cdb_value, cdb_sq_tail,
                     exp_head.dest, exp_head.value, exp_head.sq);
        end

    always @(negedge clock) begin
        cdb_grant = (grant_mode == 2) ? 1'($random(grant_seed)) : (grant_mode == 1);
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int                   err_mark;
        logic [2:0]           funct3;
        logic [1:0]           off;
        logic [1:0]           form;
        load_pipe_pkg::data_t addr;
        reset = 1'b1;
        issue_valid = 1'b0;
        issue_inst = '0;
        issue_rs1_value = '0;
        issue_rs2_value = '0;
        issue_opa_select = load_pipe_pkg::OPA_IS_RS1;
        issue_opb_select = load_pipe_pkg::OPB_IS_RS2;
        issue_dest_reg_idx = '0;
        issue_sq_tail = '0;
        mem_wr_en = 1'b0;
        mem_wr_addr = '0;
        mem_wr_data = '0;
        mem_wr_mask = 4'hf;
        cdb_grant = 1'b0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        err_mark = errors;
        check_level(issue_ready, 1'b1, "issue_ready after reset");
        check_level(cdb_valid, 1'b0, "cdb_valid after reset");
        end_test("reset", err_mark);

        // Preload every word and mirror it in the model
        mem_wr_en = 1'b1;
        for (int i = 0; i < load_pipe_pkg::MEM_WORDS; i++) begin
            mem_wr_addr = i[load_pipe_pkg::MEM_ADDR_BITS-1:0];
            mem_wr_data = load_pipe_pkg::data_t'($random(seed));
            model_mem[i] = mem_wr_data;
            @(negedge clock);
        end
        mem_wr_en = 1'b0;

        err_mark = errors;
        for (int i = 0; i < 6; i++) begin
            // Odd passes use a negative offset
            issue_load(3'b010, load_pipe_pkg::OPA_IS_RS1, load_pipe_pkg::OPB_IS_I_IMM,
                       random_word_addr(), {i[0], 11'($random(seed))});
        end
        wait_drained();
        end_test("lw", err_mark);

        err_mark = errors;
        for (int k = 0; k < 4; k++) begin
            funct3 = (k == 0) ? 3'b000 : (k == 1) ? 3'b100 : (k == 2) ? 3'b001 : 3'b101;
            for (int o = 0; o < 4; o = o + (funct3[0] ? 2 : 1)) begin
                addr = random_word_addr() | load_pipe_pkg::data_t'(o);
                issue_load(funct3, load_pipe_pkg::OPA_IS_RS1, load_pipe_pkg::OPB_IS_I_IMM,
                           addr, 12'($random(seed)));
            end
        end
        wait_drained();
        end_test("sub_word", err_mark);

        err_mark = errors;
        for (int i = 0; i < 2; i++) begin
            addr = random_word_addr();
            issue_load(3'b010, load_pipe_pkg::OPA_IS_ZERO, load_pipe_pkg::OPB_IS_I_IMM,
                       addr, addr[11:0]);
        end
        issue_load(3'b010, load_pipe_pkg::OPA_IS_RS1, load_pipe_pkg::OPB_IS_RS2,
                   random_word_addr(), 12'h000);
        issue_load(3'b010, load_pipe_pkg::OPA_IS_ZERO, load_pipe_pkg::OPB_IS_RS2,
                   random_word_addr(), 12'h000);
        issue_load(3'b010, load_pipe_pkg::OPA_IS_RS1, load_pipe_pkg::OPB_IS_S_IMM,
                   random_word_addr(), 12'hf38);
        issue_load(3'b010, load_pipe_pkg::OPA_IS_RS1, load_pipe_pkg::OPB_IS_S_IMM,
                   random_word_addr(), 12'h0a4);
        wait_drained();
        end_test("addr_forms", err_mark);

        // Stall with grant low until the whole pipe is full
        err_mark = errors;
        grant_mode <= 0;
        repeat (2) @(negedge clock);
        for (int i = 0; i < PIPE_CAPACITY - 1; i++) begin
            issue_load(3'b010, load_pipe_pkg::OPA_IS_RS1, load_pipe_pkg::OPB_IS_I_IMM,
                       random_word_addr(), 12'($random(seed)));
        end
        repeat (4) @(negedge clock);
        check_level(issue_ready, 1'b1, "issue_ready with one slot left");
        issue_load(3'b010, load_pipe_pkg::OPA_IS_RS1, load_pipe_pkg::OPB_IS_I_IMM,
                   random_word_addr(), 12'($random(seed)));
        repeat (4) @(negedge clock);
        check_level(issue_ready, 1'b0, "issue_ready with the pipe full");
        check_level(cdb_valid, 1'b1, "cdb_valid with the pipe full");
        grant_mode <= 1;
        wait_drained();
        end_test("back_pressure", err_mark);

        err_mark = errors;
        grant_mode <= 2;
        for (int i = 0; i < 200; i++) begin
            funct3 = 3'($random(seed));
            if (funct3[1:0] == 2'b11 || funct3 == 3'b110) begin
                funct3 = 3'b010;
            end
            off = 2'($random(seed));
            if (funct3[1]) begin
                off = 2'b00;
            end else if (funct3[0]) begin
                off[0] = 1'b0;
            end
            addr = random_word_addr() | load_pipe_pkg::data_t'(off);
            form = 2'($random(seed));
            case (form)
                2'd0: issue_load(funct3, load_pipe_pkg::OPA_IS_RS1,
                                 load_pipe_pkg::OPB_IS_I_IMM, addr, 12'($random(seed)));
                2'd1: issue_load(funct3, load_pipe_pkg::OPA_IS_RS1,
                                 load_pipe_pkg::OPB_IS_RS2, addr, 12'h000);
                2'd2: issue_load(funct3, load_pipe_pkg::OPA_IS_ZERO,
                                 load_pipe_pkg::OPB_IS_I_IMM, addr, addr[11:0]);
                default: issue_load(funct3, load_pipe_pkg::OPA_IS_RS1,
                                    load_pipe_pkg::OPB_IS_S_IMM, addr, 12'($random(seed)));
            endcase
            if ($random(seed) & 1) begin
                @(negedge clock);
            end
        end
        wait_drained();
        end_test("random_stream", err_mark);

        $display("Tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- load_pipe.f
src/load_pipe_pkg.sv
src/load_data_if.sv
src/load_result_if.sv
src/load_addr_stage.sv
src/load_data_stage.sv
src/data_mem.sv
src/load_buffer.sv
src/load_pipe.sv
test/tb_clock_gen.sv
test/load_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module load_pipe_tb -f load_pipe.f

./obj_dir/Vload_pipe_tb | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "Simulation reported failure, see sim.log"
    exit 1
fi

grep -q "Simulation PASSED" sim.log
